// ==== bus_ctrl.sv ====
// Bus control
// Decodes the master address against the region table, raises the
// cycle strobe of one slot and routes its acknowledge to the master.
// Unmapped cycles land on a default slave that acks at once
`timescale 1ns/100ps
`default_nettype none

module bus_ctrl (
  input  logic                           sys_rst_i,
  input  kotku_pkg::bus_adr_u            m_adr_i,
  input  logic                           m_cyc_i,
  input  logic                           m_stb_i,
  input  logic [kotku_pkg::N_SLAVES-1:0] s_ack_i,
  output logic [kotku_pkg::N_SLAVES-1:0] s_cyc_o,
  output kotku_pkg::slot_idx_t           sel_o,
  output logic                           m_ack_o
);

  import kotku_pkg::*;

  logic [19:0] adr_bits;
  slot_idx_t   slot;
  logic        cyc_en;   // Master cycle outside of reset
  logic        cyc_act;  // Cycle with strobe, a live transfer

  assign adr_bits = m_adr_i;
  assign cyc_en   = m_cyc_i & ~sys_rst_i;
  assign cyc_act  = cyc_en & m_stb_i;

  // Walk backwards so the lowest entry has the last word
  always_comb begin
    slot = S_DEF;
    for (int i = N_REGIONS - 1; i >= 0; i--) begin
      if ((adr_bits & REGION_MASK[i]) == (REGION_ADDR[i] & REGION_MASK[i])) begin
        slot = REGION_SLOT[i];
      end
    end
  end

  always_comb begin
    s_cyc_o = '0;
    if (cyc_en && slot != S_DEF) begin
      s_cyc_o[slot] = 1'b1;  // One-hot or zero
    end
  end

  always_comb begin
    if (!cyc_act) begin
      m_ack_o = 1'b0;
    end else if (slot == S_DEF) begin
      m_ack_o = 1'b1;  // Default slave, no wait states
    end else begin
      m_ack_o = s_ack_i[slot];
    end
  end

  assign sel_o = slot;

endmodule

`default_nettype wire

// ==== kbd_aud_split.sv ====
// Keyboard and audio split of the port 60h slot
// A high lane access at word offset 0 is the speaker port 61h and
// goes to audio, everything else stays with the keyboard controller
`timescale 1ns/100ps
`default_nettype none

module kbd_aud_split (
  input  logic              slot_cyc_i,
  input  kotku_pkg::wb_req_t req_i,
  input  kotku_pkg::wb_rsp_t kbd_rsp_i,
  input  logic [7:0]        aud_dat_i,
  input  logic              aud_ack_i,
  output logic              kbd_cyc_o,
  output logic              aud_cyc_o,
  output kotku_pkg::wb_rsp_t slot_rsp_o
);

  logic       aud_sel;
  logic [7:0] hi_byte;

  // Address bits 2:1 are the low port word bits
  assign aud_sel = (req_i.adr.io_view.port[1:0] == 2'b00) && req_i.sel[1];

  assign aud_cyc_o = slot_cyc_i & aud_sel;
  assign kbd_cyc_o = slot_cyc_i & ~aud_sel;

  always_comb begin
    if (aud_cyc_o) begin
      hi_byte = aud_dat_i;
    end else if (kbd_cyc_o) begin
      hi_byte = kbd_rsp_i.dat_r[15:8];
    end else begin
      hi_byte = 8'h00;
    end
  end

  assign slot_rsp_o.dat_r = {hi_byte, kbd_rsp_i.dat_r[7:0]};  // Low lane is always keyboard
  assign slot_rsp_o.ack   = (aud_cyc_o & aud_ack_i) | (kbd_cyc_o & kbd_rsp_i.ack);

endmodule

`default_nettype wire

// ==== kotku_fabric.f ====
kotku_pkg.sv
rst_debounce.sv
bus_ctrl.sv
rd_data_mux.sv
kbd_aud_split.sv
kotku_fabric.sv
tb_kotku_fabric.sv

// ==== kotku_fabric.sv ====
// System bus fabric top level
// Debounced reset, address decode, response routing, vector
// substitution and the keyboard/audio split around one master
`timescale 1ns/100ps
`default_nettype none

module kotku_fabric (
  input  logic                                      clk,
  input  logic                                      rst_lck,
  output logic                                      sys_rst_o,
  input  kotku_pkg::wb_req_t                        m_req_i,
  input  logic                                      m_cyc_i,
  input  logic                                      inta_i,
  input  logic                                      nmia_i,
  input  logic [2:0]                                iid_i,
  output logic [15:0]                               m_dat_o,
  output logic                                      m_ack_o,
  output kotku_pkg::wb_req_t                        s_req_o,
  output logic [kotku_pkg::N_SLAVES-1:0]            s_cyc_o,
  input  kotku_pkg::wb_rsp_t [kotku_pkg::N_SLAVES-1:0] s_rsp_i,
  output logic                                      kbd_cyc_o,
  input  kotku_pkg::wb_rsp_t                        kbd_rsp_i,
  output logic                                      aud_cyc_o,
  input  logic [7:0]                                aud_dat_i,
  input  logic                                      aud_ack_i
);

  import kotku_pkg::*;

  logic [N_SLAVES-1:0]       slot_cyc;
  logic [N_SLAVES-1:0]       slot_ack;
  logic [N_SLAVES-1:0][15:0] slot_dat;
  slot_idx_t                 slot_sel;
  wb_rsp_t                   kbd_slot_rsp;

  rst_debounce u_rst_debounce (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst_o)
  );

  bus_ctrl u_bus_ctrl (
    .sys_rst_i (sys_rst_o),
    .m_adr_i   (m_req_i.adr),
    .m_cyc_i   (m_cyc_i),
    .m_stb_i   (m_req_i.stb),
    .s_ack_i   (slot_ack),
    .s_cyc_o   (slot_cyc),
    .sel_o     (slot_sel),
    .m_ack_o   (m_ack_o)
  );

  kbd_aud_split u_kbd_aud_split (
    .slot_cyc_i (slot_cyc[S_KBD]),
    .req_i      (m_req_i),
    .kbd_rsp_i  (kbd_rsp_i),
    .aud_dat_i  (aud_dat_i),
    .aud_ack_i  (aud_ack_i),
    .kbd_cyc_o  (kbd_cyc_o),
    .aud_cyc_o  (aud_cyc_o),
    .slot_rsp_o (kbd_slot_rsp)
  );

  // Keyboard slot answers from the split, not from s_rsp_i
  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      if (i == int'(S_KBD)) begin
        slot_ack[i] = kbd_slot_rsp.ack;
        slot_dat[i] = kbd_slot_rsp.dat_r;
      end else begin
        slot_ack[i] = s_rsp_i[i].ack;
        slot_dat[i] = s_rsp_i[i].dat_r;
      end
    end
  end

  rd_data_mux u_rd_data_mux (
    .sel_i   (slot_sel),
    .s_dat_i (slot_dat),
    .inta_i  (inta_i),
    .nmia_i  (nmia_i),
    .iid_i   (iid_i),
    .m_dat_o (m_dat_o)
  );

  assign s_req_o = m_req_i;  // Broadcast to all slaves

  always_comb begin
    s_cyc_o        = slot_cyc;
    s_cyc_o[S_KBD] = 1'b0;  // Keyboard strobes leave through the split
  end

endmodule

`default_nettype wire

// ==== kotku_pkg.sv ====
// System bus fabric shared definitions
// Bus request and response words, address views, slot map and
// the address decode table of the 8086 memory and port spaces
`default_nettype none

package kotku_pkg;

  localparam int N_SLAVES  = 7;
  localparam int N_REGIONS = 8;
  localparam int RST_CNT_W = 10;  // Debounce counter width

  typedef logic [2:0] slot_idx_t;

  localparam slot_idx_t S_ROM   = 3'd0;
  localparam slot_idx_t S_VGA   = 3'd1;
  localparam slot_idx_t S_UART  = 3'd2;
  localparam slot_idx_t S_KBD   = 3'd3;
  localparam slot_idx_t S_GPIO  = 3'd4;
  localparam slot_idx_t S_TIMER = 3'd5;
  localparam slot_idx_t S_RAM   = 3'd6;
  localparam slot_idx_t S_DEF   = 3'd7;  // Default slave, unmapped cycles

  localparam logic [15:0] NMI_VECTOR      = 16'h0002;
  localparam logic [12:0] INT_VECTOR_BASE = 13'd1;

  // Tag low selects memory space
  typedef struct packed {
    logic        tag;
    logic [18:0] adr;  // Word address of a 1 MB space
  } mem_adr_t;

  // Tag high selects I/O space
  typedef struct packed {
    logic        tag;
    logic [3:0]  rsvd;
    logic [14:0] port;  // Port word address
  } io_adr_t;

  typedef union packed {
    mem_adr_t mem_view;
    io_adr_t  io_view;
  } bus_adr_u;

  typedef struct packed {
    bus_adr_u    adr;
    logic [15:0] dat_w;
    logic [1:0]  sel;
    logic        we;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    logic [15:0] dat_r;
    logic        ack;
  } wb_rsp_t;

  // Decode table, first match wins
  localparam logic [19:0] REGION_ADDR [N_REGIONS] = '{
    {1'b0, 19'h7FF80},  // ROM 0xFFF00-0xFFFFF
    {1'b0, 19'h50000},  // VGA 0xA0000-0xBFFFF
    {1'b1, 19'h001E0},  // VGA io 0x3C0-0x3DF
    {1'b1, 19'h001FC},  // UART io 0x3F8-0x3FF
    {1'b1, 19'h00030},  // Keyboard io 0x60, 0x64
    {1'b1, 19'h07880},  // GPIO io 0xF100-0xF103
    {1'b1, 19'h00020},  // Timer io 0x40-0x43
    {1'b0, 19'h00000}   // RAM, rest of memory
  };

  localparam logic [19:0] REGION_MASK [N_REGIONS] = '{
    {1'b1, 19'h7FF80},
    {1'b1, 19'h70000},
    {1'b1, 19'h07FF0},
    {1'b1, 19'h07FFC},
    {1'b1, 19'h07FFD},
    {1'b1, 19'h07FFE},
    {1'b1, 19'h07FFE},
    {1'b1, 19'h00000}
  };

  localparam slot_idx_t REGION_SLOT [N_REGIONS] = '{
    S_ROM, S_VGA, S_VGA, S_UART, S_KBD, S_GPIO, S_TIMER, S_RAM
  };

endpackage

`default_nettype wire

// ==== rd_data_mux.sv ====
// Read data path
// Picks the read word of the selected slot, and swaps in the
// interrupt or NMI vector during an acknowledge cycle
`timescale 1ns/100ps
`default_nettype none

module rd_data_mux (
  input  kotku_pkg::slot_idx_t                  sel_i,
  input  logic [kotku_pkg::N_SLAVES-1:0][15:0]  s_dat_i,
  input  logic                                  inta_i,
  input  logic                                  nmia_i,
  input  logic [2:0]                            iid_i,
  output logic [15:0]                           m_dat_o
);

  import kotku_pkg::*;

  logic [15:0] slot_dat;

  always_comb begin
    if (sel_i == S_DEF) begin
      slot_dat = 16'h0000;  // Unmapped reads as zero
    end else begin
      slot_dat = s_dat_i[sel_i];
    end
  end

  // NMI outranks a maskable interrupt acknowledge
  always_comb begin
    if (nmia_i) begin
      m_dat_o = NMI_VECTOR;
    end else if (inta_i) begin
      m_dat_o = {INT_VECTOR_BASE, iid_i};
    end else begin
      m_dat_o = slot_dat;
    end
  end

endmodule

`default_nettype wire

// ==== rst_debounce.sv ====
// Reset debounce
// Holds the system reset high until the raw reset has stayed
// released for a full sweep of the down-counter
`timescale 1ns/100ps
`default_nettype none

module rst_debounce (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o
);

  import kotku_pkg::*;

  logic [RST_CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt       <= '1;  // Reload on every bounce
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      sys_rst_o <= (cnt != '0);  // Falls one edge after zero is reached
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f kotku_fabric.f \
  --top-module tb_kotku_fabric -o tb_kotku_fabric

./obj_dir/tb_kotku_fabric > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi

// ==== tb_kotku_fabric.sv ====
// Testbench for the system bus fabric
// Table of bus cycles against behavioral slaves with random wait
// states, plus the reset debounce timing
`timescale 1ns/100ps
`default_nettype none

module tb_kotku_fabric;

  import kotku_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_VEC = 15;
  localparam int WATCHDOG_CYCLES = 1024 + 16 + N_VEC * 8;
  localparam logic [15:0] WR_DAT = 16'hC3A5;  // Write data of every cycle

  // tag, word adr, sel, we, inta, nmia, iid, expected slot, expected data
  typedef struct packed {
    logic        tag;
    logic [18:0] adr;
    logic [1:0]  sel;
    logic        we;
    logic        inta;
    logic        nmia;
    logic [2:0]  iid;
    slot_idx_t   slot;
    logic [15:0] dat;
  } vec_t;

  // Slave data is {slot, adr[11:0]}, audio byte is {A, adr[3:0]}
  localparam vec_t VEC_TBL [N_VEC] = '{
    '{1'b0, 19'h7FFF8, 2'b11, 1'b0, 1'b0, 1'b0, 3'd0, S_ROM,   16'h0FF8},  // 0xFFFF0
    '{1'b0, 19'h0091A, 2'b11, 1'b0, 1'b0, 1'b0, 3'd0, S_RAM,   16'h691A},
    '{1'b0, 19'h5C000, 2'b11, 1'b0, 1'b0, 1'b0, 3'd0, S_VGA,   16'h1000},  // 0xB8000
    '{1'b1, 19'h001EA, 2'b01, 1'b0, 1'b0, 1'b0, 3'd0, S_VGA,   16'h11EA},  // Port 0x3D4
    '{1'b1, 19'h001FC, 2'b01, 1'b0, 1'b0, 1'b0, 3'd0, S_UART,  16'h21FC},  // Port 0x3F8
    '{1'b1, 19'h07881, 2'b11, 1'b1, 1'b0, 1'b0, 3'd0, S_GPIO,  16'h4881},  // Port 0xF102
    '{1'b1, 19'h00021, 2'b01, 1'b0, 1'b0, 1'b0, 3'd0, S_TIMER, 16'h5021},  // Port 0x42
    '{1'b1, 19'h00180, 2'b11, 1'b0, 1'b0, 1'b0, 3'd0, S_DEF,   16'h0000},  // Port 0x300
    '{1'b1, 19'h00030, 2'b10, 1'b0, 1'b0, 1'b0, 3'd0, S_KBD,   16'hA030},  // Speaker 0x61
    '{1'b1, 19'h00030, 2'b01, 1'b0, 1'b0, 1'b0, 3'd0, S_KBD,   16'h3030},
    '{1'b1, 19'h00032, 2'b01, 1'b0, 1'b0, 1'b0, 3'd0, S_KBD,   16'h3032},  // Port 0x64
    '{1'b1, 19'h00032, 2'b10, 1'b0, 1'b0, 1'b0, 3'd0, S_KBD,   16'h3032},
    '{1'b1, 19'h00021, 2'b01, 1'b0, 1'b1, 1'b0, 3'd5, S_TIMER, 16'h000D},
    '{1'b1, 19'h00021, 2'b01, 1'b0, 1'b1, 1'b1, 3'd5, S_TIMER, 16'h0002},
    '{1'b0, 19'h7FF7F, 2'b11, 1'b0, 1'b0, 1'b0, 3'd0, S_RAM,   16'h6F7F}   // Just below ROM
  };

  logic                     clk;
  logic                     rst_lck;
  logic                     sys_rst_o;
  wb_req_t                  m_req;
  logic                     m_cyc;
  logic                     inta;
  logic                     nmia;
  logic [2:0]               iid;
  logic [15:0]              m_dat_o;
  logic                     m_ack_o;
  wb_req_t                  s_req_o;
  logic [N_SLAVES-1:0]      s_cyc_o;
  wb_rsp_t [N_SLAVES-1:0]   s_rsp;
  logic                     kbd_cyc_o;
  wb_rsp_t                  kbd_rsp;
  logic                     aud_cyc_o;
  logic [7:0]               aud_dat;
  logic                     aud_ack;

  logic [19:0] m_adr;
  logic        slave_busy;
  logic        model_rdy;
  logic [1:0]  wait_cnt;
  logic [1:0]  wait_n;  // Wait states of the current slave cycle
  integer      seed = 32'h73ee_a7ae;

  kotku_fabric DUT (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst_o),
    .m_req_i   (m_req),
    .m_cyc_i   (m_cyc),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .iid_i     (iid),
    .m_dat_o   (m_dat_o),
    .m_ack_o   (m_ack_o),
    .s_req_o   (s_req_o),
    .s_cyc_o   (s_cyc_o),
    .s_rsp_i   (s_rsp),
    .kbd_cyc_o (kbd_cyc_o),
    .kbd_rsp_i (kbd_rsp),
    .aud_cyc_o (aud_cyc_o),
    .aud_dat_i (aud_dat),
    .aud_ack_i (aud_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Behavioral slaves share one wait counter since one cycle is in flight
  assign m_adr      = m_req.adr;
  assign slave_busy = (|s_cyc_o | kbd_cyc_o | aud_cyc_o) & m_req.stb;
  assign model_rdy  = (wait_cnt == wait_n);

  always_comb begin
    for (int i = 0; i < N_SLAVES; i++) begin
      s_rsp[i].dat_r = {4'(i), m_adr[11:0]};
      s_rsp[i].ack   = s_cyc_o[i] & m_req.stb & model_rdy;
    end
  end

  assign kbd_rsp.dat_r = {4'(S_KBD), m_adr[11:0]};
  assign kbd_rsp.ack   = kbd_cyc_o & m_req.stb & model_rdy;
  assign aud_dat       = {4'hA, m_adr[3:0]};
  assign aud_ack       = aud_cyc_o & m_req.stb & model_rdy;

  always @(posedge clk) begin
    if (!rst_lck) begin
      wait_cnt <= 2'd0;
      wait_n   <= 2'($random(seed));
    end else if (slave_busy) begin
      if (model_rdy) begin
        wait_cnt <= 2'd0;
        wait_n   <= 2'($random(seed));  // Fresh wait for the next cycle
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  task automatic flag_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "Run aborted");
  endtask

  // Raw reset low for 16 cycles, then count edges until the system reset drops
  task automatic check_reset();
    logic exp_rst;
    m_cyc     = 1'b1;
    m_req.stb = 1'b1;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      assert (sys_rst_o == 1'b1) else flag_mismatch("sys_rst_o", 64'd1, 64'(sys_rst_o));
      assert (s_cyc_o == '0) else flag_mismatch("s_cyc_o", 64'd0, 64'(s_cyc_o));
      assert (m_ack_o == 1'b0) else flag_mismatch("m_ack_o", 64'd0, 64'(m_ack_o));
      m_req.adr = i[0] ? 20'h80180 : 20'h00100;  // Unmapped port or RAM
    end
    rst_lck = 1'b1;
    for (int e = 1; e <= 1024; e++) begin
      @(negedge clk);
      exp_rst = (e < 1024);
      assert (sys_rst_o == exp_rst) else flag_mismatch("sys_rst_o", 64'(exp_rst), 64'(sys_rst_o));
      if (exp_rst) begin
        assert (s_cyc_o == '0) else flag_mismatch("s_cyc_o", 64'd0, 64'(s_cyc_o));
        assert (m_ack_o == 1'b0) else flag_mismatch("m_ack_o", 64'd0, 64'(m_ack_o));
      end
      m_req.adr = e[0] ? 20'h80180 : 20'h00100;
    end
    m_cyc     = 1'b0;
    m_req.stb = 1'b0;
  endtask

  task automatic run_vector(input vec_t v);
    logic [N_SLAVES-1:0] exp_cyc;
    logic                exp_aud;
    logic                exp_kbd;
    logic                exp_ack;
    wb_req_t             exp_req;
    logic                done;
    int                  cyc_n;
    exp_cyc = '0;
    if (v.slot != S_DEF && v.slot != S_KBD) begin
      exp_cyc[v.slot] = 1'b1;
    end
    exp_aud = (v.slot == S_KBD) && (v.adr[1:0] == 2'b00) && v.sel[1];
    exp_kbd = (v.slot == S_KBD) && !exp_aud;
    exp_req = {v.tag, v.adr, WR_DAT, v.sel, v.we, 1'b1};  // Broadcast unchanged
    @(negedge clk);
    m_req.adr   = {v.tag, v.adr};
    m_req.dat_w = WR_DAT;
    m_req.sel   = v.sel;
    m_req.we    = v.we;
    m_req.stb   = 1'b1;
    m_cyc       = 1'b1;
    inta        = v.inta;
    nmia        = v.nmia;
    iid         = v.iid;
    done        = 1'b0;
    cyc_n       = 0;
    while (!done) begin
      @(posedge clk);
      exp_ack = (v.slot == S_DEF) ? 1'b1 : model_rdy;
      assert (s_req_o == exp_req) else flag_mismatch("s_req_o", 64'(exp_req), 64'(s_req_o));
      assert (s_cyc_o == exp_cyc) else flag_mismatch("s_cyc_o", 64'(exp_cyc), 64'(s_cyc_o));
      assert (aud_cyc_o == exp_aud) else flag_mismatch("aud_cyc_o", 64'(exp_aud), 64'(aud_cyc_o));
      assert (kbd_cyc_o == exp_kbd) else flag_mismatch("kbd_cyc_o", 64'(exp_kbd), 64'(kbd_cyc_o));
      assert (m_ack_o == exp_ack) else flag_mismatch("m_ack_o", 64'(exp_ack), 64'(m_ack_o));
      if (m_ack_o) begin
        assert (m_dat_o == v.dat) else flag_mismatch("m_dat_o", 64'(v.dat), 64'(m_dat_o));
        done = 1'b1;
      end
      cyc_n++;
      if (!done && cyc_n > 6) begin
        abort_run("Bus cycle was never acknowledged");
      end
    end
    @(negedge clk);
    m_cyc     = 1'b0;
    m_req.stb = 1'b0;
    inta      = 1'b0;
    nmia      = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("Watchdog expired before the test table finished");
  end

  initial begin
    rst_lck = 1'b0;
    m_req   = '0;
    m_cyc   = 1'b0;
    inta    = 1'b0;
    nmia    = 1'b0;
    iid     = 3'd0;
    check_reset();
    for (int k = 0; k < N_VEC; k++) begin
      run_vector(VEC_TBL[k]);
    end
    @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
